// File: dbg_settings.svh
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// sel_mode code of the run command ('G')
`define DBG_RUN_CMD    8'h47

// received word that halts the cpu ('H')
`define DBG_HALT_CHAR  8'h48

// dump framing characters
`define DBG_EQ_CHAR    8'h3D
`define DBG_CR_CHAR    8'h0D
`define DBG_LF_CHAR    8'h0A

`define DBG_REG_COUNT  6 // pc, ir, a, b, y, mdr
`define DBG_LABEL_MAX  3 // longest label is MDR

`endif

// File: dbg_pkg.sv
package dbg_pkg;

    typedef logic [31:0] word_t;     // data, pc, breakpoints, tx words
    typedef logic [7:0]  mode_t;     // mode selector
    typedef logic [7:0]  char_t;     // ascii character

    // register number in dump order (pc ir a b y mdr)
    typedef logic [2:0]  reg_idx_t;
    typedef logic [1:0]  char_idx_t; // position inside a label

    typedef enum logic [2:0] {
        IDLE,
        RUN,     // cpu clock running while watching for a stop
        LABEL,
        EQUALS,
        DATA,
        CR,
        LF,
        DONE     // finish held until sel_mode changes
    } dump_state_e;

endpackage

// File: dump_if.sv
`timescale 1ns/1ps

interface dump_if;
    dbg_pkg::reg_idx_t  reg_idx;
    dbg_pkg::char_idx_t char_idx;
    dbg_pkg::char_t     label_char;
    logic               label_last; // label_char is the last one of its label
    dbg_pkg::word_t     reg_word;

    modport seq (
        output reg_idx,
        output char_idx,
        input  label_char,
        input  label_last,
        input  reg_word
    );

    modport rom (
        input  reg_idx,
        input  char_idx,
        output label_char,
        output label_last,
        output reg_word
    );
endinterface

// File: run_control.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module run_control (
    input  logic           clk,
    input  logic           rstn,
    input  logic           run_en,
    input  logic           ack_rx,
    input  dbg_pkg::word_t pc_chk,
    input  dbg_pkg::word_t bp_1,
    input  dbg_pkg::word_t bp_2,
    input  dbg_pkg::word_t din_rx,
    output logic           stop_hit,
    output logic           clk_cpu,
    output logic           req_rx
);

    logic bp_match;
    logic halt_rx;

    assign bp_match = (pc_chk == bp_1) || (pc_chk == bp_2);
    assign halt_rx  = (din_rx == dbg_pkg::word_t'(`DBG_HALT_CHAR));

    // only meaningful while the cpu is running
    assign stop_hit = run_en & (bp_match | halt_rx);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            clk_cpu <= 1'b0;
        end else if (run_en) begin
            clk_cpu <= ~clk_cpu;  // half the debug clock
        end else begin
            clk_cpu <= 1'b0;
        end
    end

    // keep asking for a word while no ack is pending
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_rx <= 1'b0;
        end else if (run_en) begin
            req_rx <= ~ack_rx;
        end
    end

endmodule

// File: label_rom.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module label_rom (
    dump_if.rom            dif,
    input  dbg_pkg::word_t pc,
    input  dbg_pkg::word_t ir,
    input  dbg_pkg::word_t a,
    input  dbg_pkg::word_t b,
    input  dbg_pkg::word_t y,
    input  dbg_pkg::word_t mdr
);

    dbg_pkg::char_t     label [`DBG_LABEL_MAX];
    dbg_pkg::char_idx_t last_idx;

    always_comb begin
        label    = '{default: 8'h00};
        last_idx = '0;
        case (dif.reg_idx)
            3'd0: begin
                label    = '{"P", "C", 8'h00};
                last_idx = 2'd1;
            end
            3'd1: begin
                label    = '{"I", "R", 8'h00};
                last_idx = 2'd1;
            end
            3'd2: label = '{"A", 8'h00, 8'h00};
            3'd3: label = '{"B", 8'h00, 8'h00};
            3'd4: label = '{"Y", 8'h00, 8'h00};
            3'd5: begin
                label    = '{"M", "D", "R"};
                last_idx = 2'd2;
            end
            default: ;
        endcase
    end

    assign dif.label_char = label[dif.char_idx];
    assign dif.label_last = (dif.char_idx == last_idx);

    // snapshot word in the same order as the labels
    always_comb begin
        case (dif.reg_idx)
            3'd0:    dif.reg_word = pc;
            3'd1:    dif.reg_word = ir;
            3'd2:    dif.reg_word = a;
            3'd3:    dif.reg_word = b;
            3'd4:    dif.reg_word = y;
            3'd5:    dif.reg_word = mdr;
            default: dif.reg_word = '0;
        endcase
    end

endmodule

// File: dump_sequencer.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dump_sequencer (
    input  logic           clk,
    input  logic           rstn,
    input  dbg_pkg::mode_t sel_mode,
    input  logic           stop_hit,
    input  logic           ack_tx,
    output logic           run_en,
    output logic           req_tx,
    output logic           type_tx,
    output dbg_pkg::word_t dout,
    output logic           finish,
    dump_if.seq            dif
);

    dbg_pkg::dump_state_e state;
    dbg_pkg::dump_state_e state_nxt;
    dbg_pkg::reg_idx_t    reg_idx;
    dbg_pkg::char_idx_t   char_idx;
    logic                 cmd_run;
    logic                 taken;
    logic                 last_reg;
    logic                 tx_nxt;

    assign cmd_run  = (sel_mode == `DBG_RUN_CMD);
    assign taken    = req_tx & ack_tx;  // item accepted on this edge
    assign last_reg = (reg_idx == dbg_pkg::reg_idx_t'(`DBG_REG_COUNT - 1));
    assign run_en   = (state == dbg_pkg::RUN);

    assign dif.reg_idx  = reg_idx;
    assign dif.char_idx = char_idx;

    always_comb begin
        state_nxt = state;
        if (!cmd_run) begin
            state_nxt = dbg_pkg::IDLE;
        end else begin
            case (state)
                dbg_pkg::IDLE:   state_nxt = dbg_pkg::RUN;
                dbg_pkg::RUN:    if (stop_hit) state_nxt = dbg_pkg::LABEL;
                dbg_pkg::LABEL:  if (taken && dif.label_last) state_nxt = dbg_pkg::EQUALS;
                dbg_pkg::EQUALS: if (taken) state_nxt = dbg_pkg::DATA;
                dbg_pkg::DATA: begin
                    if (taken) begin
                        state_nxt = last_reg ? dbg_pkg::CR : dbg_pkg::LABEL;
                    end
                end
                dbg_pkg::CR:     if (taken) state_nxt = dbg_pkg::LF;
                dbg_pkg::LF:     if (taken) state_nxt = dbg_pkg::DONE;
                default: ;
            endcase
        end
    end

    // states that put an item on the tx port
    assign tx_nxt = state_nxt inside {dbg_pkg::LABEL, dbg_pkg::EQUALS, dbg_pkg::DATA,
                                      dbg_pkg::CR, dbg_pkg::LF};

    // item follows the state only, so it holds while ack_tx is low
    always_comb begin
        type_tx = 1'b0;
        dout    = '0;
        case (state)
            dbg_pkg::LABEL:  dout = dbg_pkg::word_t'(dif.label_char);
            dbg_pkg::EQUALS: dout = dbg_pkg::word_t'(`DBG_EQ_CHAR);
            dbg_pkg::DATA: begin
                type_tx = 1'b1;
                dout    = dif.reg_word;
            end
            dbg_pkg::CR:     dout = dbg_pkg::word_t'(`DBG_CR_CHAR);
            dbg_pkg::LF:     dout = dbg_pkg::word_t'(`DBG_LF_CHAR);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= dbg_pkg::IDLE;
            reg_idx  <= '0;
            char_idx <= '0;
            req_tx   <= 1'b0;
            finish   <= 1'b0;
        end else begin
            state  <= state_nxt;
            finish <= (state_nxt == dbg_pkg::DONE);
            req_tx <= tx_nxt & ~taken;  // one low cycle between items

            if (run_en) begin
                reg_idx  <= '0;
                char_idx <= '0;
            end else if (taken) begin
                case (state)
                    dbg_pkg::LABEL: char_idx <= dif.label_last ? '0 : char_idx + 1'b1;
                    dbg_pkg::DATA:  if (!last_reg) reg_idx <= reg_idx + 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: dbg_run_top.sv
`timescale 1ns/1ps

module dbg_run_top (
    input  logic           clk,
    input  logic           rstn,
    input  dbg_pkg::mode_t sel_mode,
    input  dbg_pkg::word_t pc_chk,
    input  dbg_pkg::word_t bp_1,
    input  dbg_pkg::word_t bp_2,
    input  dbg_pkg::word_t din_rx,
    input  dbg_pkg::word_t pc,
    input  dbg_pkg::word_t ir,
    input  dbg_pkg::word_t a,
    input  dbg_pkg::word_t b,
    input  dbg_pkg::word_t y,
    input  dbg_pkg::word_t mdr,
    input  logic           ack_rx,
    input  logic           ack_tx,
    output logic           req_rx,
    output logic           clk_cpu,
    output logic           req_tx,
    output logic           type_tx,
    output dbg_pkg::word_t dout,
    output logic           finish
);

    logic run_en;
    logic stop_hit;

    dump_if dif ();

    run_control u_run_control (
        .clk      (clk),
        .rstn     (rstn),
        .run_en   (run_en),
        .ack_rx   (ack_rx),
        .pc_chk   (pc_chk),
        .bp_1     (bp_1),
        .bp_2     (bp_2),
        .din_rx   (din_rx),
        .stop_hit (stop_hit),
        .clk_cpu  (clk_cpu),
        .req_rx   (req_rx)
    );

    dump_sequencer u_dump_sequencer (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .stop_hit (stop_hit),
        .ack_tx   (ack_tx),
        .run_en   (run_en),
        .req_tx   (req_tx),
        .type_tx  (type_tx),
        .dout     (dout),
        .finish   (finish),
        .dif      (dif.seq)
    );

    label_rom u_label_rom (
        .dif (dif.rom),
        .pc  (pc),
        .ir  (ir),
        .a   (a),
        .b   (b),
        .y   (y),
        .mdr (mdr)
    );

endmodule

// File: tb_dbg_run.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module tb_dbg_run;

    logic            clk;
    logic            rstn;
    dbg_pkg::mode_t  sel_mode;
    dbg_pkg::word_t  pc_chk, bp_1, bp_2, din_rx;
    dbg_pkg::word_t  pc, ir, a, b, y, mdr;
    logic            ack_rx, ack_tx;
    logic            req_rx, clk_cpu, req_tx, type_tx, finish;
    dbg_pkg::word_t  dout;

    dbg_pkg::word_t  snap [6];      // register words of the current test
    logic [35:0]     expect_q [$];  // type digit above the 32-bit data
    logic [8*24-1:0] name;
    logic [15:0]     lfsr;
    int              errors;
    int              checks;
    int              budget;        // watchdog limit in cycles

    dbg_run_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_delay();  // 0 to 3 cycles
        int d;
        d = 2 * int'(rand_bit());
        d = d + int'(rand_bit());
        return d;
    endfunction

    task automatic check_value(input string what, input logic [35:0] exp_v,
                               input logic [35:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAILED %0s %0s: expected %h, actual %h", name, what, exp_v, act_v);
        end
    endtask

    // first toggle lands two edges after the run code
    task automatic run_phase(input int run_cycles);
        logic prev_cpu;
        logic prev_ack;
        for (int i = 1; i <= run_cycles; i++) begin
            @(posedge clk);
            if (i >= 3) begin
                check_value("clk_cpu toggle", {35'd0, ~prev_cpu}, 36'(clk_cpu));
                check_value("req_rx", {35'd0, ~prev_ack}, 36'(req_rx));
            end
            prev_cpu = clk_cpu;
            prev_ack = ack_rx;
            ack_rx <= rand_bit();
            pc_chk <= 32'h0000_1000 + 32'(i * 4);  // never hits a breakpoint
        end
    endtask

    task automatic collect_dump();
        int          idx;
        int          ack_wait;
        logic        pending;
        logic [35:0] held;
        idx      = 0;
        ack_wait = rand_delay();
        pending  = 1'b0;
        held     = '0;
        while (idx < expect_q.size()) begin
            @(posedge clk);
            check_value("finish low", 36'(0), 36'(finish));
            if (pending && req_tx) begin
                check_value("held item", held, {3'd0, type_tx, dout});
            end
            if (req_tx && ack_tx) begin
                check_value($sformatf("item %0d", idx), expect_q[idx], {3'd0, type_tx, dout});
                idx++;
                ack_tx  <= 1'b0;
                ack_wait = rand_delay();
                pending  = 1'b0;
            end else if (req_tx) begin
                if (ack_wait == 0) ack_tx <= 1'b1;
                else ack_wait--;
                pending = 1'b1;
                held    = {3'd0, type_tx, dout};
            end
        end
        @(posedge clk);
        check_value("finish after lf", 36'(1), 36'(finish));
    endtask

    task automatic run_test(input int run_cycles, input int kind);
        @(posedge clk);
        {pc, ir, a, b, y} <= {snap[0], snap[1], snap[2], snap[3], snap[4]};
        mdr      <= snap[5];
        sel_mode <= `DBG_RUN_CMD;
        run_phase(run_cycles);
        case (kind)
            0: pc_chk <= bp_1;
            1: pc_chk <= bp_2;
            default: din_rx <= 32'(`DBG_HALT_CHAR);
        endcase
        collect_dump();
        repeat (3) begin
            @(posedge clk);
            check_value("finish held", 36'(1), 36'(finish));
        end
        sel_mode <= 8'h00;
        repeat (2) @(posedge clk);
        check_value("outputs after exit", 36'(0), 36'({req_tx, clk_cpu, finish}));
        pc_chk <= '0;
        din_rx <= '0;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int               fd;
        int               run_cycles;
        int               kind;
        int               n;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        logic [35:0]      tok;
        errors   = 0;
        checks   = 0;
        budget   = 200;  // reset and idle checks
        lfsr     = 16'd3;
        name     = "reset";
        rstn     <= 1'b0;
        sel_mode <= '0;
        pc_chk   <= '0;
        bp_1     <= 32'h0000_0040;
        bp_2     <= 32'h0000_0080;
        din_rx   <= '0;
        {pc, ir, a, b, y, mdr} <= '0;
        ack_rx   <= 1'b0;
        ack_tx   <= 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_value("idle outputs", 36'(0), 36'({req_tx, req_rx, clk_cpu, finish}));
        end
        fd = $fopen("dbg_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dbg_golden.txt for reading");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    void'($fgets(rest, fd));
                end else if (tag == "T") begin
                    expect_q.delete();
                    n = $fscanf(fd, "%s %d %d %h %h %h %h %h %h", name, run_cycles, kind,
                                snap[0], snap[1], snap[2], snap[3], snap[4], snap[5]);
                    if (n != 9) begin
                        errors++;
                        $display("malformed test header in dbg_golden.txt");
                    end
                end else if (tag == "I") begin
                    void'($fscanf(fd, "%d", n));
                    repeat (n) begin
                        void'($fscanf(fd, "%h", tok));
                        expect_q.push_back(tok);
                    end
                end else if (tag == "E") begin
                    budget += run_cycles + 8 * expect_q.size() + 40;
                    run_test(run_cycles, kind);
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dbg_golden.txt
# T name run_cycles stop_kind (0 bp_1, 1 bp_2, 2 halt) then pc ir a b y mdr in hex
# I count items, each item is the type digit then 8 data hex digits; E runs the test
T bp1_stop 6 0 00000100 8c220004 00000005 fffffffb 0000000a 12345678
I 4 000000050 000000043 00000003d 100000100
I 4 000000049 000000052 00000003d 18c220004
I 3 000000041 00000003d 100000005
I 3 000000042 00000003d 1fffffffb
I 3 000000059 00000003d 10000000a
I 5 00000004d 000000044 000000052 00000003d 112345678
I 2 00000000d 00000000a
E
T bp2_stop 9 1 00000080 00430820 7fffffff 00000001 80000000 deadbeef
I 4 000000050 000000043 00000003d 100000080
I 4 000000049 000000052 00000003d 100430820
I 3 000000041 00000003d 17fffffff
I 3 000000042 00000003d 100000001
I 3 000000059 00000003d 180000000
I 5 00000004d 000000044 000000052 00000003d 1deadbeef
I 2 00000000d 00000000a
E
T halt_stop 12 2 0000fffc ac010008 00000000 0000002a 0000002a a5a55a5a
I 4 000000050 000000043 00000003d 10000fffc
I 4 000000049 000000052 00000003d 1ac010008
I 3 000000041 00000003d 100000000
I 3 000000042 00000003d 10000002a
I 3 000000059 00000003d 10000002a
I 5 00000004d 000000044 000000052 00000003d 1a5a55a5a
I 2 00000000d 00000000a
E

// File: sources.f
+incdir+.
dbg_pkg.sv
dump_if.sv
run_control.sv
label_rom.sv
dump_sequencer.sv
dbg_run_top.sv
tb_dbg_run.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module tb_dbg_run \
    && ./obj_dir/Vtb_dbg_run | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -qx "Result: PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
